// ==== files.f ====
logic/com_pkg.sv
logic/com_write_arbiter.sv
logic/com_opcode_decoder.sv
logic/com_table_loader.sv
logic/com_config_write_regs.sv
logic/com_config_readback.sv
logic/com_config_top.sv
sim/tb_com_config.sv

// ==== Makefile ====
# Verilator build and run for the configuration block testbench

SIM       := verilator
SIM_FLAGS := --binary --timing --assert -j 0
TOP       := tb_com_config
FILELIST  := files.f
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/tb_com_config.sv ====
// Self-checking testbench for the configuration block top level
// Random stimulus from an LCG with seed 76, compared with a model of the stores
// Model is updated when a command is issued, reads wait out the pipeline
// Loader test assumes software sends static writes only while the loader runs

`timescale 1ns/1ps

module tb_com_config;

  localparam int cycle_limit = 4000;   // About twice the length of all tests

  logic                           fw_clk_100 = 1'b0;
  logic                           fw_rst_n;
  logic                           sw_cmd_valid;
  logic [com_pkg::cmd_w-1:0]      sw_cmd_word;
  logic [1:0]                     rd_sel;
  logic [com_pkg::tbl_addr_w-1:0] rd_addr;
  logic [com_pkg::payload_w-1:0]  rd_data;
  logic                           loader_busy;
  logic                           bad_op;

  // Reference model of the three stores
  logic [com_pkg::payload_w-1:0]  m_static;
  logic [com_pkg::tbl_data_w-1:0] m_arr0 [com_pkg::tbl_depth];
  logic [com_pkg::tbl_data_w-1:0] m_arr1 [com_pkg::tbl_depth];

  logic [31:0] lcg_state   = 32'd76;   // Seed
  int          cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          test_count  = 0;
  int          test_errors = 0;        // Errors before the current test

  com_config_top u_dut (
    .fw_clk_100   (fw_clk_100),
    .fw_rst_n     (fw_rst_n),
    .sw_cmd_valid (sw_cmd_valid),
    .sw_cmd_word  (sw_cmd_word),
    .rd_sel       (rd_sel),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .loader_busy  (loader_busy),
    .bad_op       (bad_op)
  );

  always #10 fw_clk_100 = ~fw_clk_100;   // 20 ns period

  // Watchdog
  always @(posedge fw_clk_100) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Verification failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error at time %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  function automatic void model_clear();
    m_static = '0;
    for (int i = 0; i < com_pkg::tbl_depth; i++) begin
      m_arr0[i] = '0;
      m_arr1[i] = '0;
    end
  endfunction

  // Effect of one command word on the stores
  function automatic void model_apply(input logic [31:0] word);
    logic [7:0]  op;
    logic [23:0] pl;
    op = word[31:24];
    pl = word[23:0];
    case (op)
      com_pkg::op_reset:        model_clear();
      com_pkg::op_cfg_static_0: m_static = pl;
      com_pkg::op_cfg_array_0:  m_arr0[pl[23:16]] = pl[15:0];
      com_pkg::op_cfg_array_1:  m_arr1[pl[23:16]] = pl[15:0];
      com_pkg::op_load_array_1: begin
        for (int i = 0; i < com_pkg::tbl_depth; i++) begin
          m_arr1[i] = pl[15:0] + 16'(i);   // Ramp, wraps at 2^16
        end
      end
      default: ;                         // Unknown code changes nothing
    endcase
  endfunction

  function automatic logic [23:0] model_read(input logic [1:0] sel, input logic [7:0] addr);
    case (sel)
      com_pkg::rd_static_0: return m_static;
      com_pkg::rd_array_0:  return {8'h00, m_arr0[addr]};
      com_pkg::rd_array_1:  return {8'h00, m_arr1[addr]};
      default:              return 24'h0;
    endcase
  endfunction

  task automatic send_cmd(input logic [31:0] word);
    @(posedge fw_clk_100);
    sw_cmd_valid <= 1'b1;
    sw_cmd_word  <= word;
    model_apply(word);
  endtask

  task automatic bus_idle();
    @(posedge fw_clk_100);
    sw_cmd_valid <= 1'b0;
  endtask

  // Read-back is combinational, sample at the falling edge
  task automatic read_check(input logic [1:0] sel, input logic [7:0] addr);
    @(posedge fw_clk_100);
    rd_sel  <= sel;
    rd_addr <= addr;
    @(negedge fw_clk_100);
    check(32'(rd_data), 32'(model_read(sel, addr)),
          $sformatf("read sel %0d addr %0d", sel, addr));
  endtask

  task automatic sweep_tables();
    read_check(com_pkg::rd_static_0, 8'd0);
    for (int a = 0; a < com_pkg::tbl_depth; a++) begin
      read_check(com_pkg::rd_array_0, 8'(a));
      read_check(com_pkg::rd_array_1, 8'(a));
    end
  endtask

  task automatic end_test(input string name);
    test_count++;
    $display("Test %0d %s done, %0d errors", test_count, name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [23:0] old_static;
    logic [7:0]  bad_code;
    logic        busy;
    int          waited;
    fw_rst_n     = 1'b0;
    sw_cmd_valid = 1'b0;
    sw_cmd_word  = '0;
    rd_sel       = '0;
    rd_addr      = '0;
    model_clear();
    repeat (5) @(posedge fw_clk_100);
    fw_rst_n <= 1'b1;

    // Reset state, every selector including the unused one
    @(negedge fw_clk_100);
    check(32'(loader_busy), 32'd0, "loader_busy high after reset");
    check(32'(bad_op), 32'd0, "bad_op high after reset");
    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < 2; k++) begin
        r = rand_next();
        read_check(2'(s), r[31:24]);
      end
    end
    end_test("reset state");

    // Static writes, old value through t+2, new value from t+3
    @(posedge fw_clk_100);
    rd_sel <= com_pkg::rd_static_0;
    for (int k = 0; k < 16; k++) begin
      r          = rand_next();
      old_static = m_static;
      send_cmd({com_pkg::op_cfg_static_0, r[31:8]});
      bus_idle();
      @(posedge fw_clk_100);
      @(negedge fw_clk_100);
      check(32'(rd_data), 32'(old_static), "static changed before t+3");
      @(posedge fw_clk_100);
      @(negedge fw_clk_100);
      check(32'(rd_data), 32'(m_static), "static write at t+3");
    end
    end_test("static writes");

    // Back to back table writes
    for (int k = 0; k < 200; k++) begin
      r = rand_next();
      send_cmd({r[31] ? com_pkg::op_cfg_array_1 : com_pkg::op_cfg_array_0, r[23:0]});
    end
    bus_idle();
    repeat (3) @(posedge fw_clk_100);
    sweep_tables();
    end_test("table writes");

    // Loader with software traffic on about a quarter of the cycles
    r = rand_next();
    send_cmd({com_pkg::op_load_array_1, r[23:0]});
    bus_idle();
    waited = 0;
    @(negedge fw_clk_100);
    while (!loader_busy && waited < 8) begin
      @(negedge fw_clk_100);
      waited++;
    end
    check(32'(loader_busy), 32'd1, "loader_busy low after load command");
    busy = loader_busy;
    while (busy) begin
      r = rand_next();
      @(posedge fw_clk_100);
      if (r[31:30] == 2'd0) begin
        sw_cmd_valid <= 1'b1;
        sw_cmd_word  <= {com_pkg::op_cfg_static_0, r[23:0]};
        model_apply({com_pkg::op_cfg_static_0, r[23:0]});
      end else begin
        sw_cmd_valid <= 1'b0;
      end
      @(negedge fw_clk_100);
      busy = loader_busy;
    end
    bus_idle();
    repeat (4) @(posedge fw_clk_100);   // Last loader and software writes land
    read_check(com_pkg::rd_static_0, 8'd0);
    for (int a = 0; a < com_pkg::tbl_depth; a++) begin
      read_check(com_pkg::rd_array_1, 8'(a));
    end
    end_test("loader");

    // Unknown opcode, bad_op only in t+2
    r        = rand_next();
    bad_code = 8'h06 + (r[31:24] % 8'd250);   // Codes 0x06..0xff
    send_cmd({bad_code, r[23:0]});
    bus_idle();
    @(negedge fw_clk_100);
    check(32'(bad_op), 32'd0, "bad_op high in t+1");
    @(posedge fw_clk_100);
    @(negedge fw_clk_100);
    check(32'(bad_op), 32'd1, "bad_op low in t+2");
    @(posedge fw_clk_100);
    @(negedge fw_clk_100);
    check(32'(bad_op), 32'd0, "bad_op high in t+3");
    sweep_tables();
    end_test("unknown opcode");

    // Reset opcode with a random payload
    r = rand_next();
    send_cmd({com_pkg::op_reset, r[23:0]});
    bus_idle();
    repeat (3) @(posedge fw_clk_100);
    sweep_tables();
    end_test("reset opcode");

    $display("Summary: %0d tests, %0d checks, %0d errors",
             test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== logic/com_config_top.sv ====
// Configuration block top level
// Software strobe at t reaches the bus at t+1, strobes at t+2,
// stores and rd_data at t+3
// Loader shares the bus and only proceeds in cycles without software
// Read-back is combinational from rd_sel and rd_addr

`timescale 1ns/1ps

module com_config_top (
  input  logic                           fw_clk_100,
  input  logic                           fw_rst_n,
  input  logic                           sw_cmd_valid,
  input  logic [com_pkg::cmd_w-1:0]      sw_cmd_word,
  input  logic [1:0]                     rd_sel,
  input  logic [com_pkg::tbl_addr_w-1:0] rd_addr,
  output logic [com_pkg::payload_w-1:0]  rd_data,
  output logic                           loader_busy,
  output logic                           bad_op
);

  // ----------------------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------------------
  logic                          ld_req;
  logic                          ld_grant;
  logic [com_pkg::cmd_w-1:0]     ld_word;
  logic                          bus_valid;
  logic [com_pkg::cmd_w-1:0]     bus_word;
  logic                          op_reset_stb;
  logic                          op_static_stb;
  logic                          op_array_0_stb;
  logic                          op_array_1_stb;
  logic                          op_load_stb;
  logic [com_pkg::payload_w-1:0] payload;     // Shared by loader and stores
  logic [com_pkg::payload_w-1:0] config_static_0;
  logic [com_pkg::tbl_depth-1:0][com_pkg::tbl_data_w-1:0] config_array_0;
  logic [com_pkg::tbl_depth-1:0][com_pkg::tbl_data_w-1:0] config_array_1;

  com_write_arbiter u_arbiter (
    .fw_clk_100   (fw_clk_100),
    .fw_rst_n     (fw_rst_n),
    .sw_cmd_valid (sw_cmd_valid),
    .sw_cmd_word  (sw_cmd_word),
    .ld_req       (ld_req),
    .ld_word      (ld_word),
    .ld_grant     (ld_grant),
    .bus_valid    (bus_valid),
    .bus_word     (bus_word)
  );

  com_opcode_decoder u_decoder (
    .fw_clk_100     (fw_clk_100),
    .fw_rst_n       (fw_rst_n),
    .bus_valid      (bus_valid),
    .bus_word       (bus_word),
    .op_reset_stb   (op_reset_stb),
    .op_static_stb  (op_static_stb),
    .op_array_0_stb (op_array_0_stb),
    .op_array_1_stb (op_array_1_stb),
    .op_load_stb    (op_load_stb),
    .bad_op         (bad_op),
    .payload        (payload)
  );

  com_table_loader u_loader (
    .fw_clk_100  (fw_clk_100),
    .fw_rst_n    (fw_rst_n),
    .op_load_stb (op_load_stb),
    .payload     (payload),
    .ld_grant    (ld_grant),
    .ld_req      (ld_req),
    .ld_word     (ld_word),
    .loader_busy (loader_busy)
  );

  com_config_write_regs u_regs (
    .fw_clk_100      (fw_clk_100),
    .fw_rst_n        (fw_rst_n),
    .op_reset_stb    (op_reset_stb),
    .op_static_stb   (op_static_stb),
    .op_array_0_stb  (op_array_0_stb),
    .op_array_1_stb  (op_array_1_stb),
    .payload         (payload),
    .config_static_0 (config_static_0),
    .config_array_0  (config_array_0),
    .config_array_1  (config_array_1)
  );

  com_config_readback u_readback (
    .rd_sel          (rd_sel),
    .rd_addr         (rd_addr),
    .config_static_0 (config_static_0),
    .config_array_0  (config_array_0),
    .config_array_1  (config_array_1),
    .rd_data         (rd_data)
  );

endmodule

// ==== logic/com_config_readback.sv ====
// Combinational read-back of one stored value
// Table entries are zero-extended to 24 bits, selector 3 reads zero

`timescale 1ns/1ps

module com_config_readback (
  input  logic [1:0]                    rd_sel,
  input  logic [com_pkg::tbl_addr_w-1:0] rd_addr,
  input  logic [com_pkg::payload_w-1:0] config_static_0,
  input  logic [com_pkg::tbl_depth-1:0][com_pkg::tbl_data_w-1:0] config_array_0,
  input  logic [com_pkg::tbl_depth-1:0][com_pkg::tbl_data_w-1:0] config_array_1,
  output logic [com_pkg::payload_w-1:0] rd_data
);

  localparam int pad_w = com_pkg::payload_w - com_pkg::tbl_data_w;  // Zero bits on top

  // ----------------------------------------------------------------------
  // Selector mux
  // ----------------------------------------------------------------------
  always_comb begin
    case (rd_sel)
      com_pkg::rd_static_0: rd_data = config_static_0;
      com_pkg::rd_array_0:  rd_data = {{pad_w{1'b0}}, config_array_0[rd_addr]};
      com_pkg::rd_array_1:  rd_data = {{pad_w{1'b0}}, config_array_1[rd_addr]};
      default:              rd_data = '0;   // Unused code
    endcase
  end

endmodule

// ==== logic/com_config_write_regs.sv ====
// Configuration stores written by decoder strobes
// One 24-bit static register and two 256 x 16 tables
// Reset opcode has priority and clears all three stores
// Table writes take address from payload 23..16, data from 15..0
// A strobe in cycle t updates the store at the end of t

`timescale 1ns/1ps

module com_config_write_regs (
  input  logic                          fw_clk_100,
  input  logic                          fw_rst_n,
  input  logic                          op_reset_stb,
  input  logic                          op_static_stb,
  input  logic                          op_array_0_stb,
  input  logic                          op_array_1_stb,
  input  logic [com_pkg::payload_w-1:0] payload,
  output logic [com_pkg::payload_w-1:0] config_static_0,
  output logic [com_pkg::tbl_depth-1:0][com_pkg::tbl_data_w-1:0] config_array_0,
  output logic [com_pkg::tbl_depth-1:0][com_pkg::tbl_data_w-1:0] config_array_1
);

  logic [com_pkg::tbl_addr_w-1:0] wr_addr;   // Table entry select
  logic [com_pkg::tbl_data_w-1:0] wr_data;   // Table entry value

  assign wr_addr = payload[com_pkg::payload_w-1:com_pkg::tbl_data_w];
  assign wr_data = payload[com_pkg::tbl_data_w-1:0];

  // ----------------------------------------------------------------------
  // Static register
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      config_static_0 <= '0;
    end else if (op_reset_stb) begin
      config_static_0 <= '0;
    end else if (op_static_stb) begin
      config_static_0 <= payload;   // Whole 24 bits
    end
  end

  // ----------------------------------------------------------------------
  // Table 0
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      config_array_0 <= '0;
    end else if (op_reset_stb) begin
      config_array_0 <= '0;   // Clears every entry
    end else if (op_array_0_stb) begin
      config_array_0[wr_addr] <= wr_data;
    end
  end

  // ----------------------------------------------------------------------
  // Table 1, also the loader target
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      config_array_1 <= '0;
    end else if (op_reset_stb) begin
      config_array_1 <= '0;
    end else if (op_array_1_stb) begin
      config_array_1[wr_addr] <= wr_data;
    end
  end

  // Decoder must never hand over two writes in one cycle
  a_single_write : assert property (
    @(posedge fw_clk_100) disable iff (!fw_rst_n)
      $onehot0({op_reset_stb, op_static_stb, op_array_0_stb, op_array_1_stb})
  ) else $error("two write strobes in one cycle");

endmodule

// ==== logic/com_table_loader.sv ====
// Ramp fill of table 1 through the shared command bus
// Issues entries 0..255 in order, entry i holds base + i modulo 2^16
// Base is the low 16 bits of the load command payload
// Load requests while busy are ignored, reset opcode does not stop a run

`timescale 1ns/1ps

module com_table_loader (
  input  logic                          fw_clk_100,
  input  logic                          fw_rst_n,
  input  logic                          op_load_stb,
  input  logic [com_pkg::payload_w-1:0] payload,
  input  logic                          ld_grant,
  output logic                          ld_req,
  output logic [com_pkg::cmd_w-1:0]     ld_word,
  output logic                          loader_busy
);

  logic [com_pkg::tbl_addr_w-1:0] idx;    // Entry being offered
  logic [com_pkg::tbl_data_w-1:0] ramp;   // Data for that entry
  logic                           last;   // Final entry offered

  assign last = (idx == com_pkg::tbl_addr_w'(com_pkg::tbl_depth - 1));

  // ----------------------------------------------------------------------
  // Sequencer
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      loader_busy <= 1'b0;
      idx         <= '0;
      ramp        <= '0;
    end else if (!loader_busy) begin
      if (op_load_stb) begin
        loader_busy <= 1'b1;                                // Busy next cycle
        idx         <= '0;
        ramp        <= payload[com_pkg::tbl_data_w-1:0];   // Ramp base
      end
    end else if (ld_grant) begin
      idx  <= idx + 1'b1;
      ramp <= ramp + 1'b1;   // Wraps modulo 2^16
      if (last) begin
        loader_busy <= 1'b0;   // Falls after the 256th grant
      end
    end
  end

  // Request is a level held for the whole run
  assign ld_req  = loader_busy;
  assign ld_word = {com_pkg::op_cfg_array_1, idx, ramp};

  // Arbiter must only grant a pending request
  a_grant_needs_req : assert property (
    @(posedge fw_clk_100) disable iff (!fw_rst_n)
      ld_grant |-> ld_req
  ) else $error("grant without a loader request");

endmodule

// ==== logic/com_opcode_decoder.sv ====
// Splits each bus word into a registered opcode strobe plus payload
// One cycle of latency, at most one strobe high per cycle
// Unknown opcodes raise bad_op for a single cycle and nothing else
// Payload holds its value until the next bus word

`timescale 1ns/1ps

module com_opcode_decoder (
  input  logic                          fw_clk_100,
  input  logic                          fw_rst_n,
  input  logic                          bus_valid,
  input  logic [com_pkg::cmd_w-1:0]     bus_word,
  output logic                          op_reset_stb,
  output logic                          op_static_stb,
  output logic                          op_array_0_stb,
  output logic                          op_array_1_stb,
  output logic                          op_load_stb,
  output logic                          bad_op,
  output logic [com_pkg::payload_w-1:0] payload
);

  logic [com_pkg::op_w-1:0] opcode;   // Byte 3 of the bus word

  assign opcode = bus_word[com_pkg::cmd_w-1:com_pkg::payload_w];

  // ----------------------------------------------------------------------
  // Strobes
  // ----------------------------------------------------------------------
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      op_reset_stb   <= 1'b0;
      op_static_stb  <= 1'b0;
      op_array_0_stb <= 1'b0;
      op_array_1_stb <= 1'b0;
      op_load_stb    <= 1'b0;
      bad_op         <= 1'b0;
    end else begin
      // Default low, strobes last one cycle
      op_reset_stb   <= 1'b0;
      op_static_stb  <= 1'b0;
      op_array_0_stb <= 1'b0;
      op_array_1_stb <= 1'b0;
      op_load_stb    <= 1'b0;
      bad_op         <= 1'b0;
      if (bus_valid) begin
        case (opcode)
          com_pkg::op_reset:        op_reset_stb   <= 1'b1;
          com_pkg::op_cfg_static_0: op_static_stb  <= 1'b1;
          com_pkg::op_cfg_array_0:  op_array_0_stb <= 1'b1;
          com_pkg::op_cfg_array_1:  op_array_1_stb <= 1'b1;
          com_pkg::op_load_array_1: op_load_stb    <= 1'b1;
          default:                  bad_op         <= 1'b1;  // Unknown code
        endcase
      end
    end
  end

  // Payload register, no reset
  always_ff @(posedge fw_clk_100) begin
    if (bus_valid) begin
      payload <= bus_word[com_pkg::payload_w-1:0];
    end
  end

endmodule

// ==== logic/com_write_arbiter.sv ====
// Two-way fixed-priority arbiter for the shared command bus
// Software always wins, its one-cycle strobe is never dropped
// Loader holds a level request, grant is a combinational one-cycle pulse
// Bus outputs are registered, one cycle of latency

`timescale 1ns/1ps

module com_write_arbiter (
  input  logic                      fw_clk_100,
  input  logic                      fw_rst_n,
  // Software source
  input  logic                      sw_cmd_valid,
  input  logic [com_pkg::cmd_w-1:0] sw_cmd_word,
  // Table loader source
  input  logic                      ld_req,
  input  logic [com_pkg::cmd_w-1:0] ld_word,
  output logic                      ld_grant,
  // Shared bus to the decoder
  output logic                      bus_valid,
  output logic [com_pkg::cmd_w-1:0] bus_word
);

  // Loader only gets the slots software leaves free
  assign ld_grant = ld_req & ~sw_cmd_valid;

  // Valid flag, reset to idle
  always_ff @(posedge fw_clk_100 or negedge fw_rst_n) begin
    if (!fw_rst_n) begin
      bus_valid <= 1'b0;
    end else begin
      bus_valid <= sw_cmd_valid | ld_grant;
    end
  end

  // Output mux, payload only
  always_ff @(posedge fw_clk_100) begin
    if (sw_cmd_valid) begin
      bus_word <= sw_cmd_word;          // Software first
    end else if (ld_grant) begin
      bus_word <= ld_word;
    end
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  // Loader keeps its request and its word until a grant arrives
  a_req_held : assert property (
    @(posedge fw_clk_100) disable iff (!fw_rst_n)
      (ld_req && !ld_grant) |=> (ld_req && $stable(ld_word))
  ) else $error("loader dropped or changed its request before the grant");

endmodule

// ==== logic/com_pkg.sv ====
// Shared widths, opcodes and read-back codes for the configuration block
// Command word is opcode in byte 3 and a 24-bit payload in bytes 2..0
// Table payload carries address in bits 23..16 and data in bits 15..0

package com_pkg;

  // ----------------------------------------------------------------------
  // Field widths
  // ----------------------------------------------------------------------
  localparam int cmd_w      = 32;  // Full command word
  localparam int op_w       = 8;   // Opcode, bits 31..24
  localparam int payload_w  = 24;  // Payload, bits 23..0
  localparam int tbl_addr_w = 8;   // Table address, payload 23..16
  localparam int tbl_data_w = 16;  // Table entry, payload 15..0
  localparam int tbl_depth  = 256; // Entries per table

  // ----------------------------------------------------------------------
  // Opcodes
  // ----------------------------------------------------------------------
  localparam logic [op_w-1:0] op_reset        = 8'h01; // Clear all stores
  localparam logic [op_w-1:0] op_cfg_static_0 = 8'h02; // Whole payload to static reg
  localparam logic [op_w-1:0] op_cfg_array_0  = 8'h03; // One table 0 entry
  localparam logic [op_w-1:0] op_cfg_array_1  = 8'h04; // One table 1 entry
  localparam logic [op_w-1:0] op_load_array_1 = 8'h05; // Ramp fill of table 1

  // ----------------------------------------------------------------------
  // Read-back selector codes
  // ----------------------------------------------------------------------
  // Code 3 is unused and reads zero
  localparam logic [1:0] rd_static_0 = 2'd0;
  localparam logic [1:0] rd_array_0  = 2'd1;
  localparam logic [1:0] rd_array_1  = 2'd2;

endpackage
